//--- secv_pkg.sv
// Core-wide constants for a single 64-bit hart; only the synchronous exception causes handled here exist
package secv_pkg;

    localparam int XLEN      = 64;                  // Register width
    localparam int HART_ID_W = 4;                   // Hart id input width

    // Synchronous exception causes, standard mcause codes
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGN = 4'd0,                  // Instruction address misaligned
        EXC_ILLEGAL_INSTR  = 4'd2,                  // Illegal instruction
        EXC_BREAKPOINT     = 4'd3,                  // EBREAK
        EXC_LOAD_MISALIGN  = 4'd4,                  // Load address misaligned
        EXC_STORE_MISALIGN = 4'd6,                  // Store/AMO address misaligned
        EXC_ECALL_M        = 4'd11                  // ECALL from M-mode
    } exc_t;

endpackage

//--- csr_pkg.sv
// Machine-mode CSR map of the unit; mstatus implements only MIE and MPIE, misa reports RV64 with I and U
package csr_pkg;

    // Machine information registers, read only
    localparam logic [11:0] CSR_ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_ADDR_MHARTID   = 12'hF14;

    // Machine trap setup
    localparam logic [11:0] CSR_ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_ADDR_MISA      = 12'h301;
    localparam logic [11:0] CSR_ADDR_MIE       = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam logic [11:0] CSR_ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_ADDR_MIP       = 12'h344;

    // Machine counters
    localparam logic [11:0] CSR_ADDR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_ADDR_MINSTRET  = 12'hB02;

    // Zicsr forms carried on the bus side-band
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'd0,                        // CSRRW
        CSR_OP_SET   = 2'd1,                        // CSRRS
        CSR_OP_CLEAR = 2'd2                         // CSRRC
    } csr_op_t;

    // mstatus fields
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam logic [secv_pkg::XLEN-1:0] MSTATUS_MASK =
        (64'd1 << MSTATUS_MIE) | (64'd1 << MSTATUS_MPIE);

    // MXL=2 in the top bits, extension letters I (bit 8) and U (bit 20)
    localparam logic [secv_pkg::XLEN-1:0] MISA_VALUE =
        (64'd2 << 62) | (64'd1 << 8) | (64'd1 << 20);

    // Identity words, zero vendor means non-commercial
    localparam logic [secv_pkg::XLEN-1:0] MVENDORID = 64'h0;
    localparam logic [secv_pkg::XLEN-1:0] MARCHID   = 64'h0000_0000_0000_5EC5;
    localparam logic [secv_pkg::XLEN-1:0] MIMPID    = 64'h0000_0000_0001_0000;

endpackage

//--- csr_bus_slave.sv
// Wishbone classic slave for CSR access, one access at a time, read data is always the old CSR value
module csr_bus_slave (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [11:0]               wb_adr_i,
    input  logic [secv_pkg::XLEN-1:0] wb_dat_i,
    input  csr_pkg::csr_op_t          csr_op_i,     // Valid with stb
    output logic [secv_pkg::XLEN-1:0] wb_dat_o,
    output logic                      wb_ack_o,
    output logic                      wb_err_o,
    output logic [11:0]               csr_addr_o,
    output logic [secv_pkg::XLEN-1:0] csr_wdata_o,
    output logic                      csr_we_o,
    input  logic [secv_pkg::XLEN-1:0] regs_rdata_i,
    input  logic                      regs_hit_i,
    input  logic [secv_pkg::XLEN-1:0] cnt_rdata_i,
    input  logic                      cnt_hit_i
);

    logic                      req;                 // Sampling cycle of a new access
    logic                      bad;                 // Access must end in err
    logic [secv_pkg::XLEN-1:0] old_val;             // Combined read data

    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o; // No response pending
    assign old_val = regs_rdata_i | cnt_rdata_i;    // Non-hitting block returns zero

    // Unknown address, or a write into the read-only quarter 0b11
    assign bad = ~(regs_hit_i | cnt_hit_i) | (wb_we_i & (wb_adr_i[11:10] == 2'b11));

    assign csr_addr_o = wb_adr_i;
    assign csr_we_o   = req & wb_we_i & ~bad;       // Commit on the sampling edge

    // Read-modify-write value
    always_comb begin
        case (csr_op_i)
            csr_pkg::CSR_OP_SET:   csr_wdata_o = old_val | wb_dat_i;
            csr_pkg::CSR_OP_CLEAR: csr_wdata_o = old_val & ~wb_dat_i;
            default:               csr_wdata_o = wb_dat_i; // Plain write
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            wb_ack_o <= req & ~bad;                 // One-cycle pulse, req masks the next cycle
            wb_err_o <= req & bad;
        end
    end

    // Old value captured with the response
    always_ff @(posedge clk_i) begin
        if (req) begin
            wb_dat_o <= old_val;
        end
    end

endmodule

//--- csr_regs.sv
// Trap setup and trap handling CSRs plus the identity words; trap loads override bus writes to the trap registers
module csr_regs (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic [11:0]                    csr_addr_i,
    input  logic [secv_pkg::XLEN-1:0]      csr_wdata_i,
    input  logic                           csr_we_i,
    input  logic [secv_pkg::HART_ID_W-1:0] hartid_i,
    input  logic [1:0]                     trap_load_i,    // [0] any trap event, [1] exception
    input  logic [secv_pkg::XLEN-1:0]      trap_mepc_i,
    input  logic [secv_pkg::XLEN-1:0]      trap_mcause_i,
    input  logic [secv_pkg::XLEN-1:0]      trap_mtval_i,
    input  logic [secv_pkg::XLEN-1:0]      trap_mstatus_i,
    output logic [secv_pkg::XLEN-1:0]      rdata_o,
    output logic                           hit_o,
    output logic [secv_pkg::XLEN-1:0]      mstatus_o,
    output logic [secv_pkg::XLEN-1:0]      mtvec_o,
    output logic [secv_pkg::XLEN-1:0]      mepc_o
);

    logic [secv_pkg::XLEN-1:0] mstatus;             // Only MIE and MPIE live
    logic [secv_pkg::XLEN-1:0] mie;
    logic [secv_pkg::XLEN-1:0] mtvec;
    logic [secv_pkg::XLEN-1:0] mscratch;
    logic [secv_pkg::XLEN-1:0] mepc;                // Bit 0 always low
    logic [secv_pkg::XLEN-1:0] mcause;
    logic [secv_pkg::XLEN-1:0] mtval;
    logic [secv_pkg::XLEN-1:0] mip;                 // Plain storage, nothing sets it
    logic                      bus_wr_ok;           // Bus may write the trap registers

    assign bus_wr_ok = csr_we_i & ~trap_load_i[0];  // Trap cycle drops these writes

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mip      <= '0;
        end else begin
            // Registers the trap logic never touches
            if (csr_we_i && csr_addr_i == csr_pkg::CSR_ADDR_MIE)      mie      <= csr_wdata_i;
            if (csr_we_i && csr_addr_i == csr_pkg::CSR_ADDR_MTVEC)    mtvec    <= csr_wdata_i;
            if (csr_we_i && csr_addr_i == csr_pkg::CSR_ADDR_MSCRATCH) mscratch <= csr_wdata_i;
            if (csr_we_i && csr_addr_i == csr_pkg::CSR_ADDR_MIP)      mip      <= csr_wdata_i;

            if (trap_load_i[0]) begin
                mstatus <= trap_mstatus_i & csr_pkg::MSTATUS_MASK; // Exception or mret
            end else if (bus_wr_ok && csr_addr_i == csr_pkg::CSR_ADDR_MSTATUS) begin
                mstatus <= csr_wdata_i & csr_pkg::MSTATUS_MASK;
            end

            if (trap_load_i[1]) begin               // Exception entry only
                mepc   <= {trap_mepc_i[secv_pkg::XLEN-1:1], 1'b0};
                mcause <= trap_mcause_i;
                mtval  <= trap_mtval_i;
            end else begin
                if (bus_wr_ok && csr_addr_i == csr_pkg::CSR_ADDR_MEPC) begin
                    mepc <= {csr_wdata_i[secv_pkg::XLEN-1:1], 1'b0};
                end
                if (bus_wr_ok && csr_addr_i == csr_pkg::CSR_ADDR_MCAUSE) mcause <= csr_wdata_i;
                if (bus_wr_ok && csr_addr_i == csr_pkg::CSR_ADDR_MTVAL)  mtval  <= csr_wdata_i;
            end
        end
    end

    // Read mux, zero on a miss so the slave can OR
    always_comb begin
        hit_o = 1'b1;
        case (csr_addr_i)
            csr_pkg::CSR_ADDR_MVENDORID: rdata_o = csr_pkg::MVENDORID;
            csr_pkg::CSR_ADDR_MARCHID:   rdata_o = csr_pkg::MARCHID;
            csr_pkg::CSR_ADDR_MIMPID:    rdata_o = csr_pkg::MIMPID;
            csr_pkg::CSR_ADDR_MHARTID:
                rdata_o = {{(secv_pkg::XLEN-secv_pkg::HART_ID_W){1'b0}}, hartid_i};
            csr_pkg::CSR_ADDR_MISA:      rdata_o = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_ADDR_MSTATUS:   rdata_o = mstatus;
            csr_pkg::CSR_ADDR_MIE:       rdata_o = mie;
            csr_pkg::CSR_ADDR_MTVEC:     rdata_o = mtvec;
            csr_pkg::CSR_ADDR_MSCRATCH:  rdata_o = mscratch;
            csr_pkg::CSR_ADDR_MEPC:      rdata_o = mepc;
            csr_pkg::CSR_ADDR_MCAUSE:    rdata_o = mcause;
            csr_pkg::CSR_ADDR_MTVAL:     rdata_o = mtval;
            csr_pkg::CSR_ADDR_MIP:       rdata_o = mip;
            default: begin
                rdata_o = '0;
                hit_o   = 1'b0;
            end
        endcase
    end

    assign mstatus_o = mstatus;
    assign mtvec_o   = mtvec;
    assign mepc_o    = mepc;

endmodule

//--- csr_counters.sv
// mcycle and minstret; a bus write in a cycle replaces that cycle's increment
module csr_counters (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic [11:0]               csr_addr_i,
    input  logic [secv_pkg::XLEN-1:0] csr_wdata_i,
    input  logic                      csr_we_i,
    input  logic                      retire_i,     // One instruction retired
    output logic [secv_pkg::XLEN-1:0] rdata_o,
    output logic                      hit_o
);

    logic [secv_pkg::XLEN-1:0] mcycle;
    logic [secv_pkg::XLEN-1:0] minstret;
    logic                      sel_cycle;
    logic                      sel_instret;

    assign sel_cycle   = csr_addr_i == csr_pkg::CSR_ADDR_MCYCLE;
    assign sel_instret = csr_addr_i == csr_pkg::CSR_ADDR_MINSTRET;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (csr_we_i && sel_cycle) mcycle <= csr_wdata_i; // Load wins
            else                       mcycle <= mcycle + 1'b1;

            if (csr_we_i && sel_instret) minstret <= csr_wdata_i;
            else if (retire_i)           minstret <= minstret + 1'b1;
        end
    end

    assign hit_o   = sel_cycle | sel_instret;
    assign rdata_o = sel_cycle ? mcycle : (sel_instret ? minstret : '0);

endmodule

//--- csr_trap.sv
// Trap entry and mret for M-mode only; exception beats mret, redirect follows one cycle after the event
module csr_trap (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      exc_i,
    input  secv_pkg::exc_t            exc_type_i,
    input  logic [secv_pkg::XLEN-1:0] pc_i,         // PC of the faulting instruction
    input  logic [secv_pkg::XLEN-1:0] tval_i,
    input  logic                      mret_i,
    input  logic [secv_pkg::XLEN-1:0] mstatus_i,
    input  logic [secv_pkg::XLEN-1:0] mtvec_i,
    input  logic [secv_pkg::XLEN-1:0] mepc_i,
    output logic [1:0]                trap_load_o,  // [0] any event, [1] exception
    output logic [secv_pkg::XLEN-1:0] trap_mepc_o,
    output logic [secv_pkg::XLEN-1:0] trap_mcause_o,
    output logic [secv_pkg::XLEN-1:0] trap_mtval_o,
    output logic [secv_pkg::XLEN-1:0] trap_mstatus_o,
    output logic                      trap_o,
    output logic [secv_pkg::XLEN-1:0] redirect_pc_o
);

    logic event_any;

    assign event_any   = exc_i | mret_i;
    assign trap_load_o = {exc_i, event_any};

    assign trap_mepc_o   = pc_i;
    assign trap_mtval_o  = tval_i;
    assign trap_mcause_o = {{(secv_pkg::XLEN-$bits(exc_type_i)){1'b0}}, exc_type_i}; // Bit 63 low

    // New mstatus, exception stacks MIE, mret unstacks it
    always_comb begin
        trap_mstatus_o = mstatus_i;
        if (exc_i) begin
            trap_mstatus_o[csr_pkg::MSTATUS_MPIE] = mstatus_i[csr_pkg::MSTATUS_MIE];
            trap_mstatus_o[csr_pkg::MSTATUS_MIE]  = 1'b0;
        end else begin
            trap_mstatus_o[csr_pkg::MSTATUS_MIE]  = mstatus_i[csr_pkg::MSTATUS_MPIE];
            trap_mstatus_o[csr_pkg::MSTATUS_MPIE] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) trap_o <= 1'b0;
        else       trap_o <= event_any;             // One-cycle pulse per event
    end

    // Target taken from the state before the event's edge
    always_ff @(posedge clk_i) begin
        if (exc_i) begin
            redirect_pc_o <= {mtvec_i[secv_pkg::XLEN-1:2], 2'b00}; // Direct mode only
        end else if (mret_i) begin
            redirect_pc_o <= mepc_i;
        end
    end

endmodule

//--- csr_unit.sv
// M-mode CSR unit top for one 64-bit hart; no interrupts, PMP or user mode
module csr_unit (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [11:0]                    wb_adr_i,
    input  logic [secv_pkg::XLEN-1:0]      wb_dat_i,
    output logic [secv_pkg::XLEN-1:0]      wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           wb_err_o,
    input  csr_pkg::csr_op_t               csr_op_i,
    input  logic [secv_pkg::HART_ID_W-1:0] hartid_i,
    input  logic                           exc_i,
    input  secv_pkg::exc_t                 exc_type_i,
    input  logic [secv_pkg::XLEN-1:0]      pc_i,
    input  logic [secv_pkg::XLEN-1:0]      tval_i,
    input  logic                           mret_i,
    input  logic                           retire_i,
    output logic                           trap_o,
    output logic [secv_pkg::XLEN-1:0]      redirect_pc_o
);

    // Internal CSR bus
    logic [11:0]               csr_addr;
    logic [secv_pkg::XLEN-1:0] csr_wdata;
    logic                      csr_we;
    logic [secv_pkg::XLEN-1:0] regs_rdata;
    logic                      regs_hit;
    logic [secv_pkg::XLEN-1:0] cnt_rdata;
    logic                      cnt_hit;

    // Trap path
    logic [1:0]                trap_load;
    logic [secv_pkg::XLEN-1:0] trap_mepc;
    logic [secv_pkg::XLEN-1:0] trap_mcause;
    logic [secv_pkg::XLEN-1:0] trap_mtval;
    logic [secv_pkg::XLEN-1:0] trap_mstatus;
    logic [secv_pkg::XLEN-1:0] mstatus;
    logic [secv_pkg::XLEN-1:0] mtvec;
    logic [secv_pkg::XLEN-1:0] mepc;

    csr_bus_slave slave0 (
        .clk_i, .rst_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .csr_op_i,
        .wb_dat_o, .wb_ack_o, .wb_err_o,
        .csr_addr_o   (csr_addr),
        .csr_wdata_o  (csr_wdata),
        .csr_we_o     (csr_we),
        .regs_rdata_i (regs_rdata),
        .regs_hit_i   (regs_hit),
        .cnt_rdata_i  (cnt_rdata),
        .cnt_hit_i    (cnt_hit)
    );

    csr_regs regs0 (
        .clk_i, .rst_i, .hartid_i,
        .csr_addr_i     (csr_addr),
        .csr_wdata_i    (csr_wdata),
        .csr_we_i       (csr_we),
        .trap_load_i    (trap_load),
        .trap_mepc_i    (trap_mepc),
        .trap_mcause_i  (trap_mcause),
        .trap_mtval_i   (trap_mtval),
        .trap_mstatus_i (trap_mstatus),
        .rdata_o        (regs_rdata),
        .hit_o          (regs_hit),
        .mstatus_o      (mstatus),
        .mtvec_o        (mtvec),
        .mepc_o         (mepc)
    );

    csr_counters cnt0 (
        .clk_i, .rst_i, .retire_i,
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .csr_we_i    (csr_we),
        .rdata_o     (cnt_rdata),
        .hit_o       (cnt_hit)
    );

    csr_trap trap0 (
        .clk_i, .rst_i, .exc_i, .exc_type_i, .pc_i, .tval_i, .mret_i,
        .mstatus_i      (mstatus),
        .mtvec_i        (mtvec),
        .mepc_i         (mepc),
        .trap_load_o    (trap_load),
        .trap_mepc_o    (trap_mepc),
        .trap_mcause_o  (trap_mcause),
        .trap_mtval_o   (trap_mtval),
        .trap_mstatus_o (trap_mstatus),
        .trap_o, .redirect_pc_o
    );

endmodule

//--- tb_csr_ref.svh
// Shadow of the writable CSRs and hart id; counters are not shadowed, their tests compute the expected values
`ifndef TB_CSR_REF_SVH
`define TB_CSR_REF_SVH

logic [63:0] ref_mstatus;
logic [63:0] ref_mie;
logic [63:0] ref_mtvec;
logic [63:0] ref_mscratch;
logic [63:0] ref_mepc;
logic [63:0] ref_mcause;
logic [63:0] ref_mtval;
logic [63:0] ref_mip;
logic [3:0]  ref_hartid;

// New CSR value for a Zicsr form
function automatic logic [63:0] op_result(input csr_pkg::csr_op_t op, input logic [63:0] old,
                                          input logic [63:0] opnd);
    case (op)
        csr_pkg::CSR_OP_SET:   return old | opnd;
        csr_pkg::CSR_OP_CLEAR: return old & ~opnd;
        default:               return opnd;
    endcase
endfunction

// mstatus after trap entry (stack MIE) or mret (unstack)
function automatic logic [63:0] status_after(input logic [63:0] old, input logic is_exc);
    logic [63:0] s;
    s = old;
    s[csr_pkg::MSTATUS_MPIE] = is_exc ? old[csr_pkg::MSTATUS_MIE] : 1'b1;
    s[csr_pkg::MSTATUS_MIE]  = is_exc ? 1'b0 : old[csr_pkg::MSTATUS_MPIE];
    return s;
endfunction

function automatic void model_write(input logic [11:0] addr, input logic [63:0] val);
    case (addr)
        csr_pkg::CSR_ADDR_MSTATUS:  ref_mstatus  = val & csr_pkg::MSTATUS_MASK;
        csr_pkg::CSR_ADDR_MIE:      ref_mie      = val;
        csr_pkg::CSR_ADDR_MTVEC:    ref_mtvec    = val;
        csr_pkg::CSR_ADDR_MSCRATCH: ref_mscratch = val;
        csr_pkg::CSR_ADDR_MEPC:     ref_mepc     = {val[63:1], 1'b0}; // Halfword aligned
        csr_pkg::CSR_ADDR_MCAUSE:   ref_mcause   = val;
        csr_pkg::CSR_ADDR_MTVAL:    ref_mtval    = val;
        csr_pkg::CSR_ADDR_MIP:      ref_mip      = val;
        default: ;                                  // Read-only or unknown
    endcase
endfunction

function automatic void model_trap(input logic [63:0] pc, input int code, input logic [63:0] tval);
    ref_mepc    = {pc[63:1], 1'b0};
    ref_mcause  = 64'(code);                        // Synchronous, bit 63 low
    ref_mtval   = tval;
    ref_mstatus = status_after(ref_mstatus, 1'b1);
endfunction

function automatic void model_reset();
    model_write(csr_pkg::CSR_ADDR_MSTATUS, '0);
    ref_mie      = '0;
    ref_mtvec    = '0;
    ref_mscratch = '0;
    ref_mepc     = '0;
    ref_mcause   = '0;
    ref_mtval    = '0;
    ref_mip      = '0;
endfunction

// Expected read data, also the old value of a write
function automatic logic [63:0] exp_read(input logic [11:0] addr);
    case (addr)
        csr_pkg::CSR_ADDR_MISA:      return csr_pkg::MISA_VALUE;
        csr_pkg::CSR_ADDR_MVENDORID: return csr_pkg::MVENDORID;
        csr_pkg::CSR_ADDR_MARCHID:   return csr_pkg::MARCHID;
        csr_pkg::CSR_ADDR_MIMPID:    return csr_pkg::MIMPID;
        csr_pkg::CSR_ADDR_MHARTID:   return {60'd0, ref_hartid};
        csr_pkg::CSR_ADDR_MSTATUS:   return ref_mstatus;
        csr_pkg::CSR_ADDR_MIE:       return ref_mie;
        csr_pkg::CSR_ADDR_MTVEC:     return ref_mtvec;
        csr_pkg::CSR_ADDR_MSCRATCH:  return ref_mscratch;
        csr_pkg::CSR_ADDR_MEPC:      return ref_mepc;
        csr_pkg::CSR_ADDR_MCAUSE:    return ref_mcause;
        csr_pkg::CSR_ADDR_MTVAL:     return ref_mtval;
        csr_pkg::CSR_ADDR_MIP:       return ref_mip;
        default:                     return '0;
    endcase
endfunction

`endif

//--- tb_csr_unit.sv
// Self-checking testbench for csr_unit; bus accesses run one at a time with an idle cycle after each
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 10;
    localparam int N_OPS       = 24;                // Random Zicsr accesses
    localparam int N_EXC       = 6;                 // Exception types
    localparam int N_CNT       = 3;                 // Counter rounds
    localparam int ACC_CYC     = 3;                 // Worst-case cycles per access
    // Reset, identity, Zicsr, errors, traps, counters
    localparam int TEST_CYCLES = 4 + ACC_CYC * (5 + N_OPS + 5 + 5 + N_EXC * 6) + N_EXC * 4
                                 + N_CNT * (4 * ACC_CYC + 8 + 16);

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    logic [11:0]           wb_adr_i;
    logic [63:0]           wb_dat_i;
    logic [63:0]           wb_dat_o;
    logic                  wb_ack_o;
    logic                  wb_err_o;
    csr_pkg::csr_op_t      csr_op_i;
    logic [3:0]            hartid_i;
    logic                  exc_i;
    secv_pkg::exc_t        exc_type_i;
    logic [63:0]           pc_i;
    logic [63:0]           tval_i;
    logic                  mret_i;
    logic                  retire_i;
    logic                  trap_o;
    logic [63:0]           redirect_pc_o;

    logic [63:0]           rng_state = 64'd65218;
    string                 name_q[$];
    logic [63:0]           exp_q[$];
    logic [63:0]           act_q[$];
    int                    exc_codes[N_EXC] = '{0, 2, 3, 4, 6, 11};
    logic [11:0]           id_addrs[5] = '{csr_pkg::CSR_ADDR_MISA, csr_pkg::CSR_ADDR_MVENDORID,
        csr_pkg::CSR_ADDR_MARCHID, csr_pkg::CSR_ADDR_MIMPID, csr_pkg::CSR_ADDR_MHARTID};
    logic [11:0]           rw_addrs[3] = '{csr_pkg::CSR_ADDR_MSCRATCH, csr_pkg::CSR_ADDR_MTVEC,
        csr_pkg::CSR_ADDR_MIE};

    `include "tb_csr_ref.svh"

    csr_unit dut0 (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [63:0] next_random(); // xorshift64
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    function automatic void post_compare(input string name, input logic [63:0] exp,
                                         input logic [63:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);                       // Last, the compare process keys on it
    endfunction

    // One Wishbone access, then one idle cycle; starts and ends 1 ns after an edge
    task automatic bus_access(input string name, input logic we, input logic [11:0] adr,
                              input logic [63:0] dat, input csr_pkg::csr_op_t op,
                              input logic exp_err, output logic [63:0] rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        csr_op_i = op;
        do begin
            @(posedge clk_i);
            #1;
        end while (!wb_ack_o && !wb_err_o);
        rdata = wb_dat_o;
        post_compare({name, " err"}, exp_err, wb_err_o);
        post_compare({name, " ack"}, !exp_err, wb_ack_o);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(posedge clk_i);
        #1;
        post_compare({name, " pulse"}, 0, {wb_ack_o, wb_err_o}); // Response lasts one cycle
    endtask

    task automatic read_check(input string name, input logic [11:0] adr, input logic [63:0] exp);
        logic [63:0] rd;
        bus_access(name, 1'b0, adr, '0, csr_pkg::CSR_OP_WRITE, 1'b0, rd);
        post_compare(name, exp, rd);
    endtask

    task automatic write_op(input string name, input logic [11:0] adr,
                            input csr_pkg::csr_op_t op, input logic [63:0] opnd);
        logic [63:0] rd;
        logic [63:0] old;
        old = exp_read(adr);
        bus_access(name, 1'b1, adr, opnd, op, 1'b0, rd);
        post_compare(name, old, rd);                // Old value comes back
        model_write(adr, op_result(op, old, opnd));
    endtask

    // Exception or mret for one cycle, then the redirect and the end of the pulse
    task automatic fire_event(input string name, input logic is_exc, input int code,
                              input logic [63:0] pc, input logic [63:0] tval);
        logic [63:0] target;
        target     = is_exc ? {ref_mtvec[63:2], 2'b00} : ref_mepc;
        exc_i      = is_exc;
        mret_i     = !is_exc;
        exc_type_i = secv_pkg::exc_t'(code);
        pc_i       = pc;
        tval_i     = tval;
        @(posedge clk_i);
        #1;
        exc_i  = 1'b0;
        mret_i = 1'b0;
        if (is_exc) model_trap(pc, code, tval);
        else        ref_mstatus = status_after(ref_mstatus, 1'b0);
        post_compare({name, " trap_o"}, 1, trap_o);
        post_compare({name, " redirect"}, target, redirect_pc_o);
        @(posedge clk_i);
        #1;
        post_compare({name, " trap_o end"}, 0, trap_o);
    endtask

    initial begin : compare_proc
        string       n;
        logic [63:0] e;
        logic [63:0] a;
        forever begin
            @(negedge clk_i);                       // Away from the driving and sampling points
            while (act_q.size() != 0) begin
                n = name_q.pop_front();
                e = exp_q.pop_front();
                a = act_q.pop_front();
                check_value(n, e, a);
            end
        end
    end

    initial begin : watchdog
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main_proc
        logic [63:0] rd;
        logic [63:0] v;
        logic [63:0] pc_v;
        logic [63:0] tv_v;
        int          k;
        int          n;
        rst_i      = 1'b1;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        csr_op_i   = csr_pkg::CSR_OP_WRITE;
        hartid_i   = 4'hA;
        ref_hartid = 4'hA;
        exc_i      = 1'b0;
        exc_type_i = secv_pkg::EXC_INSTR_MISALIGN;
        pc_i       = '0;
        tval_i     = '0;
        mret_i     = 1'b0;
        retire_i   = 1'b0;
        model_reset();
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        post_compare("reset outputs", 0, {wb_ack_o, wb_err_o, trap_o});

        foreach (id_addrs[i]) read_check($sformatf("identity %h", id_addrs[i]), id_addrs[i],
                                         exp_read(id_addrs[i]));

        for (int i = 0; i < N_OPS; i++) begin
            k = int'(next_random() % 3);
            v = next_random();
            write_op($sformatf("zicsr %0d", i), rw_addrs[k],
                     csr_pkg::csr_op_t'(next_random() % 3), v);
        end
        foreach (rw_addrs[i]) read_check("zicsr final", rw_addrs[i], exp_read(rw_addrs[i]));
        write_op("mstatus all ones", csr_pkg::CSR_ADDR_MSTATUS, csr_pkg::CSR_OP_WRITE, '1);
        read_check("mstatus mask", csr_pkg::CSR_ADDR_MSTATUS, exp_read(csr_pkg::CSR_ADDR_MSTATUS));

        bus_access("unimplemented read", 1'b0, 12'h7C0, '0, csr_pkg::CSR_OP_WRITE, 1'b1, rd);
        bus_access("unimplemented write", 1'b1, 12'h345, '1, csr_pkg::CSR_OP_WRITE, 1'b1, rd);
        bus_access("mvendorid write", 1'b1, csr_pkg::CSR_ADDR_MVENDORID, '1,
                   csr_pkg::CSR_OP_SET, 1'b1, rd);
        read_check("after err mscratch", csr_pkg::CSR_ADDR_MSCRATCH,
                   exp_read(csr_pkg::CSR_ADDR_MSCRATCH));
        read_check("after err mvendorid", csr_pkg::CSR_ADDR_MVENDORID,
                   exp_read(csr_pkg::CSR_ADDR_MVENDORID));

        for (int i = 0; i < N_EXC; i++) begin
            write_op("trap mstatus", csr_pkg::CSR_ADDR_MSTATUS, csr_pkg::CSR_OP_WRITE,
                     next_random());
            pc_v = next_random();
            tv_v = next_random();
            fire_event($sformatf("exception %0d", exc_codes[i]), 1'b1, exc_codes[i], pc_v, tv_v);
            read_check("trap mepc", csr_pkg::CSR_ADDR_MEPC, exp_read(csr_pkg::CSR_ADDR_MEPC));
            read_check("trap mcause", csr_pkg::CSR_ADDR_MCAUSE, exp_read(csr_pkg::CSR_ADDR_MCAUSE));
            read_check("trap mtval", csr_pkg::CSR_ADDR_MTVAL, exp_read(csr_pkg::CSR_ADDR_MTVAL));
            read_check("trap mstatus", csr_pkg::CSR_ADDR_MSTATUS,
                       exp_read(csr_pkg::CSR_ADDR_MSTATUS));
            fire_event("mret", 1'b0, 0, '0, '0);
            read_check("mret mstatus", csr_pkg::CSR_ADDR_MSTATUS,
                       exp_read(csr_pkg::CSR_ADDR_MSTATUS));
        end

        for (int i = 0; i < N_CNT; i++) begin
            v = next_random();
            bus_access("mcycle write", 1'b1, csr_pkg::CSR_ADDR_MCYCLE, v, csr_pkg::CSR_OP_WRITE,
                       1'b0, rd);
            n = int'(next_random() % 8);
            repeat (n) begin
                @(posedge clk_i);
                #1;
            end
            bus_access("mcycle read", 1'b0, csr_pkg::CSR_ADDR_MCYCLE, '0, csr_pkg::CSR_OP_WRITE,
                       1'b0, rd);
            post_compare("mcycle", v + 64'(n + 1), rd); // Idle edge plus n waits in between
            v = next_random();
            bus_access("minstret write", 1'b1, csr_pkg::CSR_ADDR_MINSTRET, v,
                       csr_pkg::CSR_OP_WRITE, 1'b0, rd);
            n = 1 + int'(next_random() % 8);
            repeat (n) begin
                retire_i = 1'b1;
                @(posedge clk_i);
                #1;
                retire_i = 1'b0;
                @(posedge clk_i);
                #1;
            end
            read_check("minstret", csr_pkg::CSR_ADDR_MINSTRET, v + 64'(n));
        end

        repeat (2) @(posedge clk_i);                // Let the compare process drain
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
secv_pkg.sv
csr_pkg.sv
csr_bus_slave.sv
csr_regs.sv
csr_counters.sv
csr_trap.sv
csr_unit.sv
tb_csr_unit.sv
